// File: hw/clint_pkg.sv
package clint_pkg;

    // widths that carry a meaning on the bus and in the register file
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;
    typedef logic [15:0] offs_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // standard single-hart CLINT layout, low 16 address bits only
    localparam offs_t OFFS_MSIP     = 16'h0000;
    localparam offs_t OFFS_MTIMECMP = 16'h4000;
    localparam offs_t OFFS_MTIME    = 16'hBFF8;

    // AXI4-Lite channel payloads
    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } axil_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } axil_ar_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_r_t;

    // single-cycle register access between the bus front end and the register block
    typedef struct packed {
        logic  write;
        offs_t offs;
        data_t data;
        strb_t strb;
    } reg_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } reg_rsp_t;

endpackage

// File: hw/clint_timer.sv
`timescale 1ns/10ps

module clint_timer #(
    parameter int TICK_DIV = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mtime_wr,
    input  logic             mtimecmp_wr,
    input  clint_pkg::data_t wdata,
    input  clint_pkg::strb_t wstrb,
    output clint_pkg::data_t mtime,
    output clint_pkg::data_t mtimecmp,
    output logic             mtip
);

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] tick_cnt;
    logic             tick;

    // apply a write to the bytes selected by the strobes
    function automatic clint_pkg::data_t byte_merge(
        input clint_pkg::data_t old_val,
        input clint_pkg::data_t new_val,
        input clint_pkg::strb_t strb
    );
        clint_pkg::data_t res;
        res = old_val;
        for (int i = 0; i < 8; i++)
        begin
            if (strb[i])
            begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign tick = (tick_cnt == DIV_W'(TICK_DIV - 1));

    // divider restarts whenever software writes mtime
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tick_cnt <= '0;
        end
        else if (mtime_wr || tick)
        begin
            tick_cnt <= '0;
        end
        else
        begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime <= '0;
        end
        else if (mtime_wr)
        begin
            mtime <= byte_merge(mtime, wdata, wstrb);
        end
        else if (tick)
        begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones keeps the timer interrupt quiet after reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtimecmp <= '1;
        end
        else if (mtimecmp_wr)
        begin
            mtimecmp <= byte_merge(mtimecmp, wdata, wstrb);
        end
    end

    // level interrupt, one cycle behind the registers
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtip <= 1'b0;
        end
        else
        begin
            mtip <= (mtime >= mtimecmp);
        end
    end

    a_mtip_cause: assert property (@(posedge clk) disable iff (!rst_n)
        mtip |-> $past(mtime >= mtimecmp))
        else $error("mtip high without a matching compare");

endmodule

// File: hw/clint_regs.sv
`timescale 1ns/10ps

module clint_regs #(
    parameter int TICK_DIV = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  clint_pkg::reg_req_t req,
    input  logic                req_valid,
    output clint_pkg::reg_rsp_t rsp,
    output logic                mtip,
    output logic                msip
);

    logic              hit_msip;
    logic              hit_mtimecmp;
    logic              hit_mtime;
    logic              wr_en;
    logic              msip_q;
    clint_pkg::data_t  mtime;
    clint_pkg::data_t  mtimecmp;

    assign hit_msip     = (req.offs == clint_pkg::OFFS_MSIP);
    assign hit_mtimecmp = (req.offs == clint_pkg::OFFS_MTIMECMP);
    assign hit_mtime    = (req.offs == clint_pkg::OFFS_MTIME);
    assign wr_en        = req_valid && req.write;

    // only bit 0 of msip exists, so only the low strobe matters
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            msip_q <= 1'b0;
        end
        else if (wr_en && hit_msip && req.strb[0])
        begin
            msip_q <= req.data[0];
        end
    end

    assign msip = msip_q;

    clint_timer #(
        .TICK_DIV    (TICK_DIV)
    ) u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .mtime_wr    (wr_en && hit_mtime),
        .mtimecmp_wr (wr_en && hit_mtimecmp),
        .wdata       (req.data),
        .wstrb       (req.strb),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .mtip        (mtip)
    );

    // read mux and response code
    always_comb
    begin
        rsp.data = '0;
        rsp.resp = clint_pkg::RESP_OKAY;
        if (hit_msip)
        begin
            rsp.data = clint_pkg::data_t'(msip_q);
        end
        else if (hit_mtimecmp)
        begin
            rsp.data = mtimecmp;
        end
        else if (hit_mtime)
        begin
            rsp.data = mtime;
        end
        else
        begin
            // unmapped offset, nothing is touched
            rsp.resp = clint_pkg::RESP_SLVERR;
        end
    end

endmodule

// File: hw/axil_reg_port.sv
`timescale 1ns/10ps

module axil_reg_port (
    input  logic                clk,
    input  logic                rst_n,

    input  clint_pkg::axil_aw_t aw,
    input  logic                awvalid,
    output logic                awready,

    input  clint_pkg::axil_w_t  w,
    input  logic                wvalid,
    output logic                wready,

    output clint_pkg::resp_t    b,
    output logic                bvalid,
    input  logic                bready,

    input  clint_pkg::axil_ar_t ar,
    input  logic                arvalid,
    output logic                arready,

    output clint_pkg::axil_r_t  r,
    output logic                rvalid,
    input  logic                rready,

    output clint_pkg::reg_req_t req,
    output logic                req_valid,
    input  clint_pkg::reg_rsp_t rsp
);

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

    wr_state_t wr_state;
    rd_state_t rd_state;
    logic      wr_ready_q;
    logic      rd_ready_q;
    logic      wr_accept;
    logic      rd_accept;
    logic      wr_hs;
    logic      rd_hs;

    // address and data must both be present before the slave commits
    assign wr_accept = (wr_state == WR_IDLE) && !wr_ready_q && awvalid && wvalid;
    // write goes first, a read arriving alongside waits one cycle
    assign rd_accept = (rd_state == RD_IDLE) && !rd_ready_q && arvalid && !wr_accept;

    assign wr_hs = wr_ready_q && awvalid && wvalid;
    assign rd_hs = rd_ready_q && arvalid;

    assign awready = wr_ready_q;
    assign wready  = wr_ready_q;
    assign arready = rd_ready_q;
    assign bvalid  = (wr_state == WR_RESP);
    assign rvalid  = (rd_state == RD_RESP);

    // write channel
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_state   <= WR_IDLE;
            wr_ready_q <= 1'b0;
        end
        else
        begin
            case (wr_state)
                WR_IDLE:
                begin
                    if (wr_hs)
                    begin
                        wr_ready_q <= 1'b0;
                        wr_state   <= WR_RESP;
                    end
                    else if (wr_accept)
                    begin
                        wr_ready_q <= 1'b1;
                    end
                end
                WR_RESP:
                begin
                    if (bready)
                    begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // read channel
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_state   <= RD_IDLE;
            rd_ready_q <= 1'b0;
        end
        else
        begin
            case (rd_state)
                RD_IDLE:
                begin
                    if (rd_hs)
                    begin
                        rd_ready_q <= 1'b0;
                        rd_state   <= RD_RESP;
                    end
                    else if (rd_accept)
                    begin
                        rd_ready_q <= 1'b1;
                    end
                end
                RD_RESP:
                begin
                    if (rready)
                    begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // response payloads captured at the handshake edge
    always_ff @(posedge clk)
    begin
        if (wr_hs)
        begin
            b <= rsp.resp;
        end
        if (rd_hs)
        begin
            r.data <= rsp.data;
            r.resp <= rsp.resp;
        end
    end

    // one request per handshake, the two never coincide
    always_comb
    begin
        if (wr_hs)
        begin
            req.write = 1'b1;
            req.offs  = aw.addr[15:0];
            req.data  = w.data;
            req.strb  = w.strb;
        end
        else
        begin
            req.write = 1'b0;
            req.offs  = ar.addr[15:0];
            req.data  = '0;
            req.strb  = '0;
        end
    end

    assign req_valid = wr_hs || rd_hs;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_no_aw_while_b: assert property (@(posedge clk) disable iff (!rst_n)
        !(awready && bvalid))
        else $error("awready raised with a write response pending");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

// File: hw/clint_top.sv
`timescale 1ns/10ps

module clint_top #(
    parameter int TICK_DIV = 1
) (
    input  logic                clk,
    input  logic                rst_n,

    input  clint_pkg::axil_aw_t aw,
    input  logic                awvalid,
    output logic                awready,

    input  clint_pkg::axil_w_t  w,
    input  logic                wvalid,
    output logic                wready,

    output clint_pkg::resp_t    b,
    output logic                bvalid,
    input  logic                bready,

    input  clint_pkg::axil_ar_t ar,
    input  logic                arvalid,
    output logic                arready,

    output clint_pkg::axil_r_t  r,
    output logic                rvalid,
    input  logic                rready,

    output logic                mtip,
    output logic                msip
);

    clint_pkg::reg_req_t req;
    clint_pkg::reg_rsp_t rsp;
    logic                req_valid;

    // bus front end
    axil_reg_port u_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp)
    );

    // register file and timer
    clint_regs #(
        .TICK_DIV  (TICK_DIV)
    ) u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .mtip      (mtip),
        .msip      (msip)
    );

endmodule

// File: bench/tb_clint.sv
`timescale 1ns/10ps

module tb_clint;

    localparam int TICK_DIV = 1;
    localparam int N_RAND   = 24;
    localparam int N_UNMAP  = 8;
    // rough count of bus operations that sizes the watchdog
    localparam int N_OPS    = 100;

    logic                clk = 1'b0;
    logic                rst_n;
    clint_pkg::axil_aw_t aw;
    logic                awvalid;
    logic                awready;
    clint_pkg::axil_w_t  w;
    logic                wvalid;
    logic                wready;
    clint_pkg::resp_t    b;
    logic                bvalid;
    logic                bready;
    clint_pkg::axil_ar_t ar;
    logic                arvalid;
    logic                arready;
    clint_pkg::axil_r_t  r;
    logic                rvalid;
    logic                rready;
    logic                mtip;
    logic                msip;

    longint unsigned     cycle = 0;
    logic [31:0]         rng_state = 32'h8d91;
    int                  errors = 0;
    int                  checks = 0;

    // reference model of the register file
    logic                model_msip;
    clint_pkg::data_t    model_mtimecmp;
    clint_pkg::data_t    model_mtime;
    longint unsigned     model_mtime_cycle;

    clint_top #(
        .TICK_DIV (TICK_DIV)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .b        (b),
        .bvalid   (bvalid),
        .bready   (bready),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready),
        .mtip     (mtip),
        .msip     (msip)
    );

    always #50 clk = ~clk;

    // edge counter for the mtime bounds
    always @(posedge clk)
    begin
        cycle <= cycle + 64'd1;
    end

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic clint_pkg::data_t rand_data();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand_next();
        lo = rand_next();
        return {hi, lo};
    endfunction

    function automatic int rand_stall();
        logic [31:0] t;
        t = rand_next();
        return {30'd0, t[1:0]};
    endfunction

    // random junk in the upper address bits that are not decoded
    function automatic clint_pkg::addr_t make_addr(input clint_pkg::offs_t offs);
        logic [31:0] t1;
        logic [31:0] t2;
        t1 = rand_next();
        t2 = rand_next();
        return {t1, t2[15:0], offs};
    endfunction

    function automatic clint_pkg::data_t strobe_merge(
        input clint_pkg::data_t old_val,
        input clint_pkg::data_t wr_val,
        input clint_pkg::strb_t strb
    );
        clint_pkg::data_t mask;
        for (int i = 0; i < 8; i++)
        begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        return (old_val & ~mask) | (wr_val & mask);
    endfunction

    // mtime is only ever written with all strobes set
    task automatic apply_write(
        input clint_pkg::offs_t offs,
        input clint_pkg::data_t data,
        input clint_pkg::strb_t strb,
        input longint unsigned  hs_cycle
    );
        if (offs == clint_pkg::OFFS_MSIP)
        begin
            if (strb[0])
            begin
                model_msip = data[0];
            end
        end
        else if (offs == clint_pkg::OFFS_MTIMECMP)
        begin
            model_mtimecmp = strobe_merge(model_mtimecmp, data, strb);
        end
        else if (offs == clint_pkg::OFFS_MTIME)
        begin
            model_mtime       = data;
            model_mtime_cycle = hs_cycle;
        end
    endtask

    task automatic check_data(
        input clint_pkg::data_t got,
        input clint_pkg::data_t exp,
        input string            what
    );
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(
        input clint_pkg::resp_t got,
        input clint_pkg::resp_t exp,
        input string            what
    );
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t: %s, got resp %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_range(
        input clint_pkg::data_t got,
        input clint_pkg::data_t lo,
        input clint_pkg::data_t hi,
        input string            what
    );
        checks++;
        if (got < lo || got > hi)
        begin
            errors++;
            $display("FAIL %0t: %s, got %h outside %h..%h", $time, what, got, lo, hi);
        end
    endtask

    // mtime counts up by one per edge after the last write
    task automatic check_mtime(
        input clint_pkg::data_t got,
        input longint unsigned  ar_cycle,
        input string            what
    );
        clint_pkg::data_t hi;
        hi = model_mtime + (ar_cycle - model_mtime_cycle) + 64'd1;
        check_range(got, model_mtime, hi, what);
    endtask

    task automatic write_reg(
        input  clint_pkg::addr_t addr,
        input  clint_pkg::data_t data,
        input  clint_pkg::strb_t strb,
        input  int               stall,
        output clint_pkg::resp_t resp,
        output longint unsigned  hs_cycle
    );
        @(posedge clk);
        aw.addr <= addr;
        aw.prot <= 3'b000;
        w.data  <= data;
        w.strb  <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready)
        begin
            @(negedge clk);
        end
        check_bit(wready, 1'b1, "wready together with awready");
        // bvalid rises at the coming write handshake edge
        @(posedge clk);
        hs_cycle = cycle;
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (stall) @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        if (!bvalid)
        begin
            errors++;
            $display("write response was not valid after the write handshake");
        end
        resp = b;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic read_reg(
        input  clint_pkg::addr_t addr,
        input  int               stall,
        output clint_pkg::data_t data,
        output clint_pkg::resp_t resp,
        output longint unsigned  hs_cycle
    );
        @(posedge clk);
        ar.addr <= addr;
        ar.prot <= 3'b010;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready)
        begin
            @(negedge clk);
        end
        // read data is taken at the coming edge
        @(posedge clk);
        hs_cycle = cycle;
        arvalid <= 1'b0;
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        if (!rvalid)
        begin
            errors++;
            $display("read response was not valid after the address handshake");
        end
        data = r.data;
        resp = r.resp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic readback_all(input string what);
        clint_pkg::data_t rdata;
        clint_pkg::resp_t resp;
        longint unsigned  ac;
        read_reg(make_addr(clint_pkg::OFFS_MSIP), 0, rdata, resp, ac);
        check_resp(resp, clint_pkg::RESP_OKAY, {what, " msip resp"});
        check_data(rdata, {63'd0, model_msip}, {what, " msip"});
        read_reg(make_addr(clint_pkg::OFFS_MTIMECMP), 0, rdata, resp, ac);
        check_resp(resp, clint_pkg::RESP_OKAY, {what, " mtimecmp resp"});
        check_data(rdata, model_mtimecmp, {what, " mtimecmp"});
        read_reg(make_addr(clint_pkg::OFFS_MTIME), 0, rdata, resp, ac);
        check_resp(resp, clint_pkg::RESP_OKAY, {what, " mtime resp"});
        check_mtime(rdata, ac, {what, " mtime"});
    endtask

    initial
    begin
        repeat (N_OPS * 40) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", N_OPS * 40);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin : tests
        clint_pkg::addr_t a;
        clint_pkg::addr_t a2;
        clint_pkg::data_t wdata;
        clint_pkg::data_t rdata;
        clint_pkg::data_t prev;
        clint_pkg::resp_t resp;
        clint_pkg::resp_t resp2;
        clint_pkg::offs_t offs;
        logic [31:0]      t;
        longint unsigned  hs;
        longint unsigned  ac;
        int               s;
        int               k;

        rst_n   <= 1'b0;
        aw      <= '0;
        awvalid <= 1'b0;
        w       <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        ar      <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        model_msip        = 1'b0;
        model_mtimecmp    = '1;
        model_mtime       = '0;
        model_mtime_cycle = cycle;

        // reset state
        @(negedge clk);
        check_bit(awready, 1'b0, "awready after reset");
        check_bit(wready, 1'b0, "wready after reset");
        check_bit(arready, 1'b0, "arready after reset");
        check_bit(bvalid, 1'b0, "bvalid after reset");
        check_bit(rvalid, 1'b0, "rvalid after reset");
        check_bit(mtip, 1'b0, "mtip after reset");
        check_bit(msip, 1'b0, "msip after reset");
        readback_all("reset");
        read_reg(make_addr(clint_pkg::OFFS_MTIME), 0, rdata, resp, ac);
        check_range(rdata, '0, 64'd63, "mtime small after reset");

        // strobed writes and readback under back-pressure
        for (int n = 0; n < N_RAND; n++)
        begin
            t     = rand_next();
            offs  = t[0] ? clint_pkg::OFFS_MTIMECMP : clint_pkg::OFFS_MSIP;
            a     = make_addr(offs);
            wdata = rand_data();
            t     = rand_next();
            s     = rand_stall();
            write_reg(a, wdata, t[7:0], s, resp, hs);
            check_resp(resp, clint_pkg::RESP_OKAY, "strobed write resp");
            apply_write(offs, wdata, t[7:0], hs);
            @(negedge clk);
            check_bit(msip, model_msip, "msip output");
            s = rand_stall();
            read_reg(a, s, rdata, resp, ac);
            check_resp(resp, clint_pkg::RESP_OKAY, "strobed readback resp");
            if (offs == clint_pkg::OFFS_MSIP)
            begin
                check_data(rdata, {63'd0, model_msip}, "msip readback");
            end
            else
            begin
                check_data(rdata, model_mtimecmp, "mtimecmp readback");
            end
        end

        // mtime counting with the top bits cleared so the count cannot wrap
        for (int n = 0; n < 2; n++)
        begin
            wdata = rand_data() & 64'h00FF_FFFF_FFFF_FFFF;
            a     = make_addr(clint_pkg::OFFS_MTIME);
            s     = rand_stall();
            write_reg(a, wdata, 8'hFF, s, resp, hs);
            check_resp(resp, clint_pkg::RESP_OKAY, "mtime write resp");
            apply_write(clint_pkg::OFFS_MTIME, wdata, 8'hFF, hs);
            prev = '0;
            for (int m = 0; m < 4; m++)
            begin
                a = make_addr(clint_pkg::OFFS_MTIME);
                s = rand_stall();
                read_reg(a, s, rdata, resp, ac);
                check_resp(resp, clint_pkg::RESP_OKAY, "mtime read resp");
                check_mtime(rdata, ac, "mtime after write");
                if (m > 0)
                begin
                    check_range(rdata, prev, '1, "mtime never decreases");
                end
                prev = rdata;
            end
        end

        // unmapped offsets
        for (int n = 0; n < N_UNMAP; n++)
        begin
            do
            begin
                t    = rand_next();
                offs = t[15:0];
            end
            while (offs == clint_pkg::OFFS_MSIP || offs == clint_pkg::OFFS_MTIMECMP ||
                   offs == clint_pkg::OFFS_MTIME);
            a     = make_addr(offs);
            wdata = rand_data();
            t     = rand_next();
            s     = rand_stall();
            write_reg(a, wdata, t[7:0], s, resp, hs);
            check_resp(resp, clint_pkg::RESP_SLVERR, "unmapped write resp");
            s = rand_stall();
            read_reg(a, s, rdata, resp, ac);
            check_resp(resp, clint_pkg::RESP_SLVERR, "unmapped read resp");
            check_data(rdata, '0, "unmapped read data");
        end
        readback_all("after unmapped");

        // timer interrupt
        read_reg(make_addr(clint_pkg::OFFS_MTIME), 0, rdata, resp, ac);
        check_mtime(rdata, ac, "mtime before arming");
        wdata = rdata + 64'd30;
        write_reg(make_addr(clint_pkg::OFFS_MTIMECMP), wdata, 8'hFF, 0, resp, hs);
        apply_write(clint_pkg::OFFS_MTIMECMP, wdata, 8'hFF, hs);
        @(negedge clk);
        check_bit(mtip, 1'b0, "mtip just after arming");
        k = 0;
        while (!mtip && k < 40)
        begin
            @(negedge clk);
            k++;
        end
        check_bit(mtip, 1'b1, "mtip within 40 cycles");
        repeat (5)
        begin
            @(negedge clk);
            check_bit(mtip, 1'b1, "mtip stays high");
        end
        write_reg(make_addr(clint_pkg::OFFS_MTIMECMP), '1, 8'hFF, 0, resp, hs);
        apply_write(clint_pkg::OFFS_MTIMECMP, '1, 8'hFF, hs);
        @(negedge clk);
        check_bit(mtip, 1'b0, "mtip after disarming");

        // read and write issued together in both register orders
        wdata = rand_data();
        a     = make_addr(clint_pkg::OFFS_MTIMECMP);
        a2    = make_addr(clint_pkg::OFFS_MSIP);
        fork
            write_reg(a, wdata, 8'hFF, 0, resp, hs);
            read_reg(a2, 0, rdata, resp2, ac);
        join
        check_resp(resp, clint_pkg::RESP_OKAY, "joint mtimecmp write resp");
        check_resp(resp2, clint_pkg::RESP_OKAY, "joint msip read resp");
        check_data(rdata, {63'd0, model_msip}, "joint msip read");
        apply_write(clint_pkg::OFFS_MTIMECMP, wdata, 8'hFF, hs);

        wdata = {63'd0, ~model_msip};
        a     = make_addr(clint_pkg::OFFS_MSIP);
        a2    = make_addr(clint_pkg::OFFS_MTIMECMP);
        fork
            write_reg(a, wdata, 8'h01, 0, resp, hs);
            read_reg(a2, 0, rdata, resp2, ac);
        join
        check_resp(resp, clint_pkg::RESP_OKAY, "joint msip write resp");
        check_resp(resp2, clint_pkg::RESP_OKAY, "joint mtimecmp read resp");
        check_data(rdata, model_mtimecmp, "joint mtimecmp read");
        apply_write(clint_pkg::OFFS_MSIP, wdata, 8'h01, hs);
        readback_all("after joint access");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
hw/clint_pkg.sv
hw/clint_timer.sv
hw/clint_regs.sv
hw/axil_reg_port.sv
hw/clint_top.sv
bench/tb_clint.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0 --timescale 1ns/10ps
TOP      = tb_clint
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
